// ==== rtl/gsim_num_pkg.sv ====
package gsim_num_pkg;

        localparam int N_UNK      = 16;
        localparam int IDX_W      = 4;
        localparam int B_W        = 16;
        localparam int X_W        = 32;         // Q16.16
        localparam int FRAC_W     = 16;
        localparam int SUM_W      = 38;         // Room for 20x a 33-bit pair sum
        localparam int PIPE_DEPTH = 4;

        typedef logic signed [B_W-1:0] gsim_b_t;
        typedef logic signed [X_W-1:0] gsim_x_t;
        typedef logic [IDX_W-1:0]      gsim_idx_t;

        // Old value and its six neighbours, edges already zeroed
        typedef struct packed {
                gsim_x_t m3;
                gsim_x_t m2;
                gsim_x_t m1;
                gsim_x_t x_old;
                gsim_x_t p1;
                gsim_x_t p2;
                gsim_x_t p3;
        } gsim_window_t;

endpackage

// ==== rtl/gsim_ctrl_pkg.sv ====
package gsim_ctrl_pkg;

        typedef enum logic [2:0] {
                IDLE,
                LOAD,
                SWEEP,
                DRAIN,
                SWAP,
                EMIT
        } gsim_state_e;

        // Rides along with the data through the update pipeline
        typedef struct packed {
                logic                    valid;
                gsim_num_pkg::gsim_idx_t idx;
        } gsim_issue_t;

        typedef struct packed {
                logic load_en;
                logic issue_en;
                logic emit_en;
                logic swap;
                logic clear;
        } gsim_ctrl_t;

        typedef struct packed {
                gsim_num_pkg::gsim_idx_t idx;
                logic                    idx_last;
                logic                    drain_done;
                logic                    sweeps_done;
        } gsim_cnt_t;

endpackage

// ==== rtl/gsim_control.sv ====
`timescale 1ns/1ns

module gsim_control (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  logic                      in_en_i,
        input  gsim_ctrl_pkg::gsim_cnt_t  cnt_i,
        output gsim_ctrl_pkg::gsim_ctrl_t ctrl_o,
        output logic                      out_valid_o
);
        import gsim_ctrl_pkg::*;

        gsim_state_e state_q;
        gsim_state_e state_d;

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        state_q     <= IDLE;
                        out_valid_o <= 1'b0;
                end else begin
                        state_q     <= state_d;
                        out_valid_o <= ctrl_o.emit_en;  // Lines up with registered x
                end
        end

        always_comb begin
                state_d = state_q;
                case (state_q)
                        IDLE: begin
                                if (in_en_i) state_d = LOAD;
                        end
                        LOAD: begin
                                if (in_en_i && cnt_i.idx_last) state_d = SWEEP;
                        end
                        SWEEP: begin
                                if (cnt_i.idx_last) state_d = DRAIN;
                        end
                        DRAIN: begin
                                if (cnt_i.drain_done) state_d = SWAP;
                        end
                        SWAP: begin
                                state_d = cnt_i.sweeps_done ? EMIT : SWEEP;
                        end
                        EMIT: begin
                                if (cnt_i.idx_last) state_d = IDLE;
                        end
                        default: state_d = IDLE;
                endcase
        end

        always_comb begin
                ctrl_o = '0;
                case (state_q)
                        IDLE: begin
                                ctrl_o.load_en = in_en_i;       // b0 arrives here
                                ctrl_o.clear   = in_en_i;
                        end
                        LOAD: begin
                                ctrl_o.load_en = in_en_i;
                        end
                        SWEEP: begin
                                ctrl_o.issue_en = 1'b1;
                        end
                        SWAP: begin
                                ctrl_o.swap = 1'b1;
                        end
                        EMIT: begin
                                ctrl_o.emit_en = 1'b1;
                        end
                        default: ctrl_o = '0;   // DRAIN just waits
                endcase
        end

endmodule

// ==== rtl/gsim_sweep_counter.sv ====
`timescale 1ns/1ns

module gsim_sweep_counter #(
        parameter int ITERATIONS = 8
) (
        input  logic                      clk,
        input  logic                      rst_n_i,
        input  gsim_ctrl_pkg::gsim_ctrl_t ctrl_i,
        output gsim_ctrl_pkg::gsim_cnt_t  cnt_o
);
        import gsim_num_pkg::*;

        localparam int SWEEP_W = $clog2(ITERATIONS + 1);
        localparam int DRAIN_W = $clog2(PIPE_DEPTH);

        gsim_idx_t          idx_q;
        logic [DRAIN_W-1:0] drain_q;
        logic [SWEEP_W-1:0] sweep_q;
        logic               step;
        logic               idx_last;

        assign step     = ctrl_i.load_en | ctrl_i.issue_en | ctrl_i.emit_en;
        assign idx_last = (idx_q == gsim_idx_t'(N_UNK - 1));

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        idx_q   <= '0;
                        drain_q <= '0;
                        sweep_q <= '0;
                end else if (ctrl_i.clear) begin
                        idx_q   <= gsim_idx_t'(ctrl_i.load_en); // First b taken this cycle
                        drain_q <= '0;
                        sweep_q <= '0;
                end else begin
                        if (step) idx_q <= idx_last ? '0 : idx_q + 1'b1;
                        if (step || ctrl_i.swap) begin
                                drain_q <= '0;
                        end else begin
                                drain_q <= drain_q + 1'b1;      // Only meaningful in DRAIN
                        end
                        if (ctrl_i.swap) sweep_q <= sweep_q + 1'b1;
                end
        end

        assign cnt_o.idx         = idx_q;
        assign cnt_o.idx_last    = idx_last;
        assign cnt_o.drain_done  = (drain_q == DRAIN_W'(PIPE_DEPTH - 1));
        assign cnt_o.sweeps_done = (sweep_q == SWEEP_W'(ITERATIONS - 1));  // At last swap

endmodule

// ==== rtl/gsim_b_store.sv ====
`timescale 1ns/1ns

module gsim_b_store (
        input  logic                      clk,
        input  gsim_ctrl_pkg::gsim_ctrl_t ctrl_i,
        input  gsim_num_pkg::gsim_idx_t   idx_i,
        input  gsim_num_pkg::gsim_b_t     b_i,
        output gsim_num_pkg::gsim_b_t     b_o
);
        import gsim_num_pkg::*;

        gsim_b_t mem_q [N_UNK];

        // Written only while a problem streams in
        always_ff @(posedge clk) begin
                if (ctrl_i.load_en) begin
                        mem_q[idx_i] <= b_i;
                end
        end

        assign b_o = mem_q[idx_i];      // Same index as the window

endmodule

// ==== rtl/gsim_x_bank.sv ====
`timescale 1ns/1ns

module gsim_x_bank (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  gsim_ctrl_pkg::gsim_ctrl_t  ctrl_i,
        input  gsim_num_pkg::gsim_idx_t    idx_i,
        input  gsim_ctrl_pkg::gsim_issue_t wr_i,
        input  gsim_num_pkg::gsim_x_t      x_i,
        output gsim_num_pkg::gsim_window_t window_o,
        output gsim_num_pkg::gsim_x_t      x_o
);
        import gsim_num_pkg::*;

        gsim_x_t bank_q [2][N_UNK];
        gsim_x_t taps [7];
        logic    sel_q;         // Read bank
        logic    wr_sel;

        assign wr_sel = ~sel_q;

        always_ff @(posedge clk) begin
                if (!rst_n_i || ctrl_i.clear) begin
                        sel_q <= 1'b0;
                end else if (ctrl_i.swap) begin
                        sel_q <= ~sel_q;
                end
        end

        always_ff @(posedge clk) begin
                if (ctrl_i.clear) begin
                        for (int b = 0; b < 2; b++) begin
                                for (int i = 0; i < N_UNK; i++) begin
                                        bank_q[b][i] <= '0;
                                end
                        end
                end else if (wr_i.valid) begin
                        bank_q[wr_sel][wr_i.idx] <= x_i;
                end
        end

        // Offsets -3..+3 around idx_i
        always_comb begin
                int pos;
                for (int k = 0; k < 7; k++) begin
                        pos = int'(idx_i) + k - 3;
                        if (pos >= 0 && pos < N_UNK) begin
                                taps[k] = bank_q[sel_q][IDX_W'(pos)];
                        end else begin
                                taps[k] = '0;   // Outside the band
                        end
                end
        end

        assign window_o = '{
                m3:    taps[0],
                m2:    taps[1],
                m1:    taps[2],
                x_old: taps[3],
                p1:    taps[4],
                p2:    taps[5],
                p3:    taps[6]
        };

        always_ff @(posedge clk) begin
                if (ctrl_i.emit_en) begin
                        x_o <= bank_q[sel_q][idx_i];
                end
        end

endmodule

// ==== rtl/gsim_update_pipe.sv ====
`timescale 1ns/1ns

module gsim_update_pipe (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  gsim_ctrl_pkg::gsim_issue_t issue_i,
        input  gsim_num_pkg::gsim_window_t window_i,
        input  gsim_num_pkg::gsim_b_t      b_i,
        output gsim_ctrl_pkg::gsim_issue_t issue_o,
        output gsim_num_pkg::gsim_x_t      x_o
);
        import gsim_num_pkg::*;
        import gsim_ctrl_pkg::*;

        localparam int DIAG = 20;
        localparam int W1   = 13;       // Off-diagonal magnitudes
        localparam int W2   = 6;

        typedef logic signed [X_W:0]     pair_t;
        typedef logic signed [SUM_W-1:0] sum_t;

        gsim_issue_t s1_issue;
        gsim_issue_t s2_issue;
        gsim_issue_t s3_issue;
        gsim_x_t     s1_old;
        gsim_x_t     s2_old;
        gsim_x_t     s3_old;
        gsim_b_t     s1_b;
        pair_t       s1_pair1;
        pair_t       s1_pair2;
        pair_t       s1_pair3;
        sum_t        s2_sum;
        sum_t        s3_quot;
        sum_t        avg;

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        s1_issue <= '0;
                        s2_issue <= '0;
                        s3_issue <= '0;
                        issue_o  <= '0;
                end else begin
                        s1_issue <= issue_i;
                        s2_issue <= s1_issue;
                        s3_issue <= s2_issue;
                        issue_o  <= s3_issue;
                end
        end

        assign avg = (s3_quot + sum_t'(s3_old)) >>> 1;

        always_ff @(posedge clk) begin
                // Stage 1
                s1_pair1 <= pair_t'(window_i.m1) + pair_t'(window_i.p1);
                s1_pair2 <= pair_t'(window_i.m2) + pair_t'(window_i.p2);
                s1_pair3 <= pair_t'(window_i.m3) + pair_t'(window_i.p3);
                s1_old   <= window_i.x_old;
                s1_b     <= b_i;
                // Stage 2, b lands in the integer half
                s2_sum   <= (sum_t'(s1_b) <<< FRAC_W)
                            + W1 * sum_t'(s1_pair1)
                            - W2 * sum_t'(s1_pair2)
                            + sum_t'(s1_pair3);
                s2_old   <= s1_old;
                // Stage 3
                s3_quot  <= s2_sum / DIAG;      // Truncates toward zero
                s3_old   <= s2_old;
                // Stage 4, result wraps to 32 bits
                x_o      <= avg[X_W-1:0];
        end

endmodule

// ==== rtl/gsim_top.sv ====
`timescale 1ns/1ns

module gsim_top #(
        parameter int ITERATIONS = 8
) (
        input  logic                  clk,
        input  logic                  rst_n_i,
        input  logic                  in_en_i,
        input  gsim_num_pkg::gsim_b_t b_i,
        output logic                  out_valid_o,
        output gsim_num_pkg::gsim_x_t x_o
);
        import gsim_num_pkg::*;
        import gsim_ctrl_pkg::*;

        gsim_ctrl_t   ctrl;
        gsim_cnt_t    cnt;
        gsim_issue_t  issue;
        gsim_issue_t  wr;
        gsim_window_t window;
        gsim_b_t      b_rd;
        gsim_x_t      x_new;

        assign issue = '{valid: ctrl.issue_en, idx: cnt.idx};

        gsim_control u_control (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .in_en_i     (in_en_i),
                .cnt_i       (cnt),
                .ctrl_o      (ctrl),
                .out_valid_o (out_valid_o)
        );

        gsim_sweep_counter #(
                .ITERATIONS (ITERATIONS)
        ) u_counter (
                .clk     (clk),
                .rst_n_i (rst_n_i),
                .ctrl_i  (ctrl),
                .cnt_o   (cnt)
        );

        gsim_b_store u_b_store (
                .clk    (clk),
                .ctrl_i (ctrl),
                .idx_i  (cnt.idx),
                .b_i    (b_i),
                .b_o    (b_rd)
        );

        gsim_x_bank u_x_bank (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .ctrl_i   (ctrl),
                .idx_i    (cnt.idx),
                .wr_i     (wr),
                .x_i      (x_new),
                .window_o (window),
                .x_o      (x_o)
        );

        gsim_update_pipe u_pipe (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .issue_i  (issue),
                .window_i (window),
                .b_i      (b_rd),
                .issue_o  (wr),
                .x_o      (x_new)
        );

endmodule

// ==== tests/gsim_model.svh ====
`ifndef GSIM_MODEL_SVH
`define GSIM_MODEL_SVH

gsim_b_t model_b [N_UNK];
gsim_x_t model_x [N_UNK];
longint  model_prev [N_UNK];    // Vector of the previous sweep
int      test_errs;

// Neighbours outside the band read as zero
function automatic longint band_val(input int pos);
        if (pos < 0 || pos >= N_UNK) begin
                return 0;
        end
        return model_prev[pos];
endfunction

// Damped Jacobi in 64-bit arithmetic, wrapped to 32 bits per sweep
task automatic solve_model();
        longint acc;
        longint quot;
        longint relaxed;
        for (int i = 0; i < N_UNK; i++) begin
                model_x[i] = '0;
        end
        for (int s = 0; s < ITERATIONS; s++) begin
                for (int i = 0; i < N_UNK; i++) begin
                        model_prev[i] = longint'(model_x[i]);
                end
                for (int i = 0; i < N_UNK; i++) begin
                        acc = longint'(model_b[i]) * 65536;     // b into Q16.16
                        acc = acc + 13 * (band_val(i - 1) + band_val(i + 1));
                        acc = acc - 6 * (band_val(i - 2) + band_val(i + 2));
                        acc = acc + (band_val(i - 3) + band_val(i + 3));
                        quot = acc / 20;
                        relaxed = (quot + model_prev[i]) >>> 1;
                        model_x[i] = relaxed[X_W-1:0];
                end
        end
endtask

task automatic check_x(input string name, input int idx, input gsim_x_t exp_x,
                       input gsim_x_t act_x);
        if (act_x !== exp_x) begin
                test_errs++;
                $display("[ERROR] %s x[%0d] expected 32'h%08h actual 32'h%08h",
                         name, idx, exp_x, act_x);
        end
endtask

task automatic check_count(input string name, input int count);
        if (count != N_UNK) begin
                test_errs++;
                $display("[ERROR] %s output count expected %0d actual %0d", name, N_UNK, count);
        end
endtask

task automatic check_valid(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
                test_errs++;
                $display("[ERROR] %s out_valid_o expected %b actual %b", name, exp_v, act_v);
        end
endtask

`endif

// ==== tests/gsim_tb.sv ====
`timescale 1ns/1ns

module gsim_tb;
        import gsim_num_pkg::*;

        localparam int ITERATIONS     = 8;
        localparam int NUM_PROBLEMS   = 21;
        localparam int TIMEOUT_CYCLES =
                NUM_PROBLEMS * (N_UNK + 1 + ITERATIONS * 21 + N_UNK + 10) * 2;

        logic        clk;
        logic        rst_n_i;
        logic        in_en_i;
        gsim_b_t     b_i;
        logic        out_valid_o;
        gsim_x_t     x_o;
        gsim_x_t     got [$];           // Outputs of the current problem
        int          pass_cnt;
        int          fail_cnt;
        int          cycle_cnt;

        `include "gsim_model.svh"

        gsim_top #(
                .ITERATIONS (ITERATIONS)
        ) UUT (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .in_en_i     (in_en_i),
                .b_i         (b_i),
                .out_valid_o (out_valid_o),
                .x_o         (x_o)
        );

        always #5 clk = ~clk;

        always @(posedge clk) begin
                if (rst_n_i && out_valid_o) begin
                        got.push_back(x_o);
                end
        end

        task automatic finish_test(input string name);
                if (test_errs == 0) begin
                        pass_cnt++;
                        $display("test %s: pass", name);
                end else begin
                        fail_cnt++;
                        $display("test %s: %0d errors", name, test_errs);
                end
        endtask

        task automatic fill_rhs(input gsim_b_t v);
                for (int i = 0; i < N_UNK; i++) begin
                        model_b[i] = v;
                end
        endtask

        task automatic fill_random();
                for (int i = 0; i < N_UNK; i++) begin
                        model_b[i] = gsim_b_t'($urandom());
                end
        endtask

        // Entered and left on a falling edge
        task automatic pulse_junk(input int cycles);
                for (int k = 0; k < cycles; k++) begin
                        in_en_i = 1'b1;
                        b_i     = gsim_b_t'($urandom());
                        @(negedge clk);
                end
                in_en_i = 1'b0;
                b_i     = '0;
        endtask

        task automatic load_problem();
                for (int i = 0; i < N_UNK; i++) begin
                        in_en_i = 1'b1;
                        b_i     = model_b[i];
                        @(negedge clk);
                end
                in_en_i = 1'b0;
                b_i     = '0;
        endtask

        task automatic run_problem(input string name, input bit junk, input int settle);
                solve_model();
                test_errs = 0;
                got.delete();
                load_problem();
                if (junk) begin
                        repeat (20) @(negedge clk);     // Well inside the sweeps
                        pulse_junk(3);
                        repeat (60) @(negedge clk);
                        pulse_junk(1);
                end
                while (got.size() < 4) @(negedge clk);
                if (junk) begin
                        pulse_junk(1);  // Still in EMIT
                end
                while (got.size() < N_UNK) @(negedge clk);
                repeat (settle) @(negedge clk);
                check_count(name, got.size());
                for (int i = 0; i < N_UNK && i < got.size(); i++) begin
                        check_x(name, i, model_x[i], got[i]);
                end
                finish_test(name);
        endtask

        initial begin
                cycle_cnt = 0;
                while (cycle_cnt < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        cycle_cnt++;
                end
                $display("Timeout after %0d cycles, the DUT did not deliver all outputs",
                         cycle_cnt);
                $display("TESTBENCH FAILED");
                $finish;
        end

        initial begin
                void'($urandom(32'heea3_bacf));
                clk      = 1'b0;
                rst_n_i  = 1'b0;
                in_en_i  = 1'b0;
                b_i      = '0;
                pass_cnt = 0;
                fail_cnt = 0;
                repeat (5) @(negedge clk);
                rst_n_i = 1'b1;

                test_errs = 0;
                repeat (20) begin
                        @(negedge clk);
                        check_valid("reset_quiet", 1'b0, out_valid_o);
                end
                finish_test("reset_quiet");

                for (int n = 0; n < 10; n++) begin
                        fill_random();
                        run_problem($sformatf("random_%0d", n), 1'b0, 10);
                end

                fill_rhs(16'sh7fff);
                run_problem("all_max", 1'b0, 10);
                fill_rhs(gsim_b_t'(16'h8000));
                run_problem("all_min", 1'b0, 10);
                for (int i = 0; i < N_UNK; i++) begin
                        model_b[i] = (i % 2) ? gsim_b_t'(16'h8000) : 16'sh7fff;
                end
                run_problem("alternating", 1'b0, 10);

                fill_rhs('0);
                run_problem("zero_rhs", 1'b0, 10);
                model_b[0] = 16'sh1234;
                run_problem("edge_low", 1'b0, 10);
                model_b[0]         = '0;
                model_b[N_UNK - 1] = -16'sh1234;
                run_problem("edge_high", 1'b0, 10);

                for (int n = 0; n < 3; n++) begin
                        fill_random();
                        run_problem($sformatf("back_to_back_%0d", n), 1'b0, (n == 2) ? 10 : 0);
                end

                for (int n = 0; n < 2; n++) begin
                        fill_random();
                        run_problem($sformatf("junk_in_en_%0d", n), 1'b1, 10);
                end

                $display("tests run %0d, passed %0d, failed %0d",
                         pass_cnt + fail_cnt, pass_cnt, fail_cnt);
                if (fail_cnt == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

// ==== gsim.f ====
+incdir+tests
rtl/gsim_num_pkg.sv
rtl/gsim_ctrl_pkg.sv
rtl/gsim_control.sv
rtl/gsim_sweep_counter.sv
rtl/gsim_b_store.sv
rtl/gsim_x_bank.sv
rtl/gsim_update_pipe.sv
rtl/gsim_top.sv
tests/gsim_tb.sv
